//--- mem_pipe.f
source/mem_pkg.sv
source/mem_ctrl.sv
source/store_align.sv
source/data_ram.sv
source/load_align.sv
source/mem_pipe.sv
test/mem_pipe_asserts.sv
test/mem_pipe_tb.sv

//--- run.sh
#!/bin/sh
# build the simulator from the file list, then run it
cd "$(dirname "$0")" &&
    verilator --binary --assert --top-module mem_pipe_tb -f mem_pipe.f -o mem_pipe_sim &&
    ./obj_dir/mem_pipe_sim ||
    { echo "build or simulation failed"; exit 1; }

//--- source/data_ram.sv
module data_ram (
    input  logic                       clk,
    input  logic                       we,
    input  logic [3:0]                 be,
    input  logic [mem_pkg::ram_aw-1:0] waddr,
    input  mem_pkg::data_word_t        wdata,
    input  logic                       re,
    input  logic [mem_pkg::ram_aw-1:0] raddr,
    output mem_pkg::data_word_t        rd_word
);
    import mem_pkg::*;

    data_word_t mem [ram_depth];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[waddr].bytes[i] <= wdata.bytes[i];
                end
            end
        end
    end

    // read word only moves on a new read, so it outlives a stall
    always_ff @(posedge clk) begin
        if (re) begin
            rd_word <= mem[raddr];
        end
    end

endmodule

//--- source/load_align.sv
module load_align (
    input  logic [mem_pkg::op_w-1:0] ms_op,
    input  logic [31:0]              ms_addr,
    input  logic [31:0]              ms_rt,
    input  mem_pkg::data_word_t      rd_word,
    output logic [31:0]              ms_result
);
    import mem_pkg::*;

    logic [1:0]  offset;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic [31:0] merge_left;
    logic [31:0] merge_right;

    assign offset    = ms_addr[1:0];
    assign byte_lane = rd_word.bytes[offset];
    assign half_lane = rd_word.halves[offset[1]];  // offset[0] is flagged upstream

    // lwl keeps the low bytes of rt
    always_comb begin
        case (offset)
            2'd0:    merge_left = {rd_word.bytes[0], ms_rt[23:0]};
            2'd1:    merge_left = {rd_word.halves[0], ms_rt[15:0]};
            2'd2:    merge_left = {rd_word.bytes[2:0], ms_rt[7:0]};
            default: merge_left = rd_word;
        endcase
    end

    // lwr keeps the high bytes of rt
    always_comb begin
        case (offset)
            2'd0:    merge_right = rd_word;
            2'd1:    merge_right = {ms_rt[31:24], rd_word.bytes[3:1]};
            2'd2:    merge_right = {ms_rt[31:16], rd_word.halves[1]};
            default: merge_right = {ms_rt[31:8], rd_word.bytes[3]};
        endcase
    end

    always_comb begin
        case (ms_op)
            OP_LB:   ms_result = {{24{byte_lane[7]}}, byte_lane};
            OP_LBU:  ms_result = {24'd0, byte_lane};
            OP_LH:   ms_result = {{16{half_lane[15]}}, half_lane};
            OP_LHU:  ms_result = {16'd0, half_lane};
            OP_LW:   ms_result = rd_word;
            OP_LWL:  ms_result = merge_left;
            OP_LWR:  ms_result = merge_right;
            default: ms_result = ms_addr;  // pass-through and stores give the alu value
        endcase
    end

endmodule

//--- source/mem_ctrl.sv
module mem_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_allowin,
    input  logic [mem_pkg::op_w-1:0] in_op,
    input  logic [31:0]              in_addr,
    input  logic [31:0]              in_rt,
    input  logic [4:0]               in_dest,
    input  logic                     in_we,
    output logic                     m1_fire,
    output logic [mem_pkg::op_w-1:0] m1_op,
    output logic [31:0]              m1_addr,
    output logic [31:0]              m1_rt,
    output logic                     m1_ex,
    output logic [mem_pkg::op_w-1:0] ms_op,
    output logic [31:0]              ms_addr,
    output logic [31:0]              ms_rt,
    output logic                     out_valid,
    input  logic                     out_allowin,
    output logic                     out_we,
    output logic [4:0]               out_dest,
    output logic                     out_ex,
    input  logic                     mem_stall
);
    import mem_pkg::*;

    logic       m1_valid;
    logic [4:0] m1_dest;
    logic       m1_we;
    logic       m1_half;
    logic       m1_word;
    logic       ms_valid;
    logic       ms_ready_go;
    logic       ms_allowin;

    // alignment check on the m1 payload
    assign m1_half = (m1_op == OP_LH) || (m1_op == OP_LHU) || (m1_op == OP_SH);
    assign m1_word = (m1_op == OP_LW) || (m1_op == OP_SW);
    assign m1_ex   = (m1_half && m1_addr[0]) ||
                     (m1_word && (m1_addr[1:0] != 2'b00));

    // ms waits while the data side is busy
    assign ms_ready_go = !mem_stall;
    assign ms_allowin  = !ms_valid || (ms_ready_go && out_allowin);
    assign out_valid   = ms_valid && ms_ready_go;

    // m1 is always ready, so it only waits on ms
    assign m1_fire    = m1_valid && ms_allowin;
    assign in_allowin = !m1_valid || ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            m1_valid <= 1'b0;
        end else if (in_allowin) begin
            m1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= m1_valid;
        end
    end

    // m1 payload, loaded on the input handshake
    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            m1_op   <= in_op;
            m1_addr <= in_addr;  // address or alu result
            m1_rt   <= in_rt;
            m1_dest <= in_dest;
            m1_we   <= in_we;
        end
    end

    // ms payload, loaded on the m1 to ms transfer
    always_ff @(posedge clk) begin
        if (m1_fire) begin
            ms_op    <= m1_op;
            ms_addr  <= m1_addr;
            ms_rt    <= m1_rt;  // old register value for lwl/lwr
            out_dest <= m1_dest;
            out_we   <= m1_we;
            out_ex   <= m1_ex;
        end
    end

endmodule

//--- source/mem_pipe.sv
module mem_pipe (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_allowin,
    input  logic [mem_pkg::op_w-1:0] in_op,
    input  logic [31:0]              in_addr,
    input  logic [31:0]              in_rt,
    input  logic [4:0]               in_dest,
    input  logic                     in_we,
    output logic                     out_valid,
    input  logic                     out_allowin,
    output logic                     out_we,
    output logic [4:0]               out_dest,
    output logic [31:0]              out_result,
    output logic                     out_ex,
    output logic [4:0]               fwd_dest,
    output logic [31:0]              fwd_result,
    input  logic                     mem_stall
);
    import mem_pkg::*;

    logic              m1_fire;
    logic [op_w-1:0]   m1_op;
    logic [31:0]       m1_addr;
    logic [31:0]       m1_rt;
    logic              m1_ex;
    logic              m1_is_load;
    logic              m1_is_store;
    logic [op_w-1:0]   ms_op;
    logic [31:0]       ms_addr;
    logic [31:0]       ms_rt;
    logic [31:0]       ms_result;
    logic [3:0]        wr_be;
    data_word_t        wr_data;
    data_word_t        rd_word;
    logic              ram_we;
    logic              ram_re;
    logic [ram_aw-1:0] ram_addr;

    mem_ctrl i_ctrl (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_allowin  (in_allowin),
        .in_op       (in_op),
        .in_addr     (in_addr),
        .in_rt       (in_rt),
        .in_dest     (in_dest),
        .in_we       (in_we),
        .m1_fire     (m1_fire),
        .m1_op       (m1_op),
        .m1_addr     (m1_addr),
        .m1_rt       (m1_rt),
        .m1_ex       (m1_ex),
        .ms_op       (ms_op),
        .ms_addr     (ms_addr),
        .ms_rt       (ms_rt),
        .out_valid   (out_valid),
        .out_allowin (out_allowin),
        .out_we      (out_we),
        .out_dest    (out_dest),
        .out_ex      (out_ex),
        .mem_stall   (mem_stall)
    );

    store_align i_store_align (
        .m1_op   (m1_op),
        .m1_addr (m1_addr[1:0]),
        .m1_rt   (m1_rt),
        .wr_be   (wr_be),
        .wr_data (wr_data)
    );

    assign m1_is_load  = m1_op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
    assign m1_is_store = m1_op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};

    // ram is touched only on the m1 to ms edge; a misaligned store never writes
    assign ram_we   = m1_fire && m1_is_store && !m1_ex;
    assign ram_re   = m1_fire && m1_is_load;
    assign ram_addr = m1_addr[ram_aw+1:2];  // upper address bits ignored

    data_ram i_ram (
        .clk     (clk),
        .we      (ram_we),
        .be      (wr_be),
        .waddr   (ram_addr),
        .wdata   (wr_data),
        .re      (ram_re),
        .raddr   (ram_addr),
        .rd_word (rd_word)
    );

    load_align i_load_align (
        .ms_op     (ms_op),
        .ms_addr   (ms_addr),
        .ms_rt     (ms_rt),
        .rd_word   (rd_word),
        .ms_result (ms_result)
    );

    assign out_result = ms_result;

    // forwarding back to decode, zero dest when nothing valid leaves
    assign fwd_dest   = out_valid ? out_dest : 5'd0;
    assign fwd_result = ms_result;

endmodule

//--- source/mem_pkg.sv
package mem_pkg;

    localparam int op_w = 4;

    // operation codes, loads first, then stores
    localparam logic [op_w-1:0] OP_PASS = 4'd0;  // alu result only
    localparam logic [op_w-1:0] OP_LB   = 4'd1;
    localparam logic [op_w-1:0] OP_LBU  = 4'd2;
    localparam logic [op_w-1:0] OP_LH   = 4'd3;
    localparam logic [op_w-1:0] OP_LHU  = 4'd4;
    localparam logic [op_w-1:0] OP_LW   = 4'd5;
    localparam logic [op_w-1:0] OP_LWL  = 4'd6;  // merge with rt
    localparam logic [op_w-1:0] OP_LWR  = 4'd7;
    localparam logic [op_w-1:0] OP_SB   = 4'd8;
    localparam logic [op_w-1:0] OP_SH   = 4'd9;
    localparam logic [op_w-1:0] OP_SW   = 4'd10;
    localparam logic [op_w-1:0] OP_SWL  = 4'd11;  // partial word stores
    localparam logic [op_w-1:0] OP_SWR  = 4'd12;

    // data ram geometry
    localparam int ram_aw    = 8;  // word index bits
    localparam int ram_depth = 1 << ram_aw;

    // one data word, either as byte lanes or as half-word lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } data_word_t;

endpackage

//--- source/store_align.sv
module store_align (
    input  logic [mem_pkg::op_w-1:0] m1_op,
    input  logic [1:0]               m1_addr,
    input  logic [31:0]              m1_rt,
    output logic [3:0]               wr_be,
    output mem_pkg::data_word_t      wr_data
);
    import mem_pkg::*;

    logic [4:0] left_shift;   // bit shift for the swl part
    logic [4:0] right_shift;  // bit shift for the swr part

    assign left_shift  = {~m1_addr, 3'b000};
    assign right_shift = {m1_addr, 3'b000};

    always_comb begin
        wr_be          = 4'b0000;
        wr_data.bytes  = m1_rt;
        case (m1_op)
            OP_SB: begin
                wr_data.bytes = {4{m1_rt[7:0]}};  // same byte in every lane
                wr_be         = 4'b0001 << m1_addr;
            end
            OP_SH: begin
                wr_data.halves = {2{m1_rt[15:0]}};
                wr_be          = m1_addr[1] ? 4'b1100 : 4'b0011;
            end
            OP_SW: begin
                wr_be = 4'b1111;
            end
            OP_SWL: begin
                // high bytes of rt land from the word start up to addr
                wr_data.bytes = m1_rt >> left_shift;
                wr_be         = 4'b1111 >> (2'd3 - m1_addr);
            end
            OP_SWR: begin
                // low bytes of rt land from addr up to the word end
                wr_data.bytes = m1_rt << right_shift;
                wr_be         = 4'b1111 << m1_addr;
            end
            default: begin
                wr_be = 4'b0000;  // not a store
            end
        endcase
    end

endmodule

//--- test/mem_pipe_asserts.sv
module mem_pipe_asserts (
    input logic       clk,
    input logic       reset,
    input logic       in_allowin,
    input logic       out_valid,
    input logic       out_allowin,
    input logic [4:0] out_dest,
    input logic [4:0] fwd_dest,
    input logic       ram_we
);

    // both valid bits clear on reset
    reset_clears_output: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high right after a reset cycle");

    reset_opens_input: assert property (@(posedge clk) reset |=> in_allowin)
        else $error("in_allowin low one cycle after reset");

    reset_blocks_write: assert property (@(posedge clk) reset |=> !ram_we)
        else $error("ram write enable active right after reset");

    held_item: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin |=> $stable(out_dest))
        else $error("ms item changed while the output side held it");

    fwd_masked: assert property (@(posedge clk) disable iff (reset)
        !out_valid |-> fwd_dest == 5'd0)
        else $error("fwd_dest nonzero with no valid output");

endmodule

//--- test/mem_pipe_tb.sv
module mem_pipe_tb;
    import mem_pkg::*;

    localparam logic [15:0] seed = 16'd25473;
    localparam int n_random    = 200;
    localparam int total_ops   = 32 + 48 + 28 + 8 + 25 + n_random;
    localparam int cycle_limit = 4 * total_ops + 100;

    logic            clk = 1'b0;
    logic            reset;
    logic            in_valid;
    logic            in_allowin;
    logic [op_w-1:0] in_op;
    logic [31:0]     in_addr;
    logic [31:0]     in_rt;
    logic [4:0]      in_dest;
    logic            in_we;
    logic            out_valid;
    logic            out_allowin;
    logic            out_we;
    logic [4:0]      out_dest;
    logic [31:0]     out_result;
    logic            out_ex;
    logic [4:0]      fwd_dest;
    logic [31:0]     fwd_result;
    logic            mem_stall;

    logic [15:0] lfsr_state;
    logic [31:0] shadow [16];   // model of the 16 words under test
    logic        random_ready;  // out_allowin and mem_stall from the lfsr
    logic        timed;         // fixed two cycle latency expected
    logic        in_fire;
    string       test_name;
    int          cycle = 0;
    int          accepted = 0;
    int          retired = 0;
    logic [31:0] ref_result;
    logic        ref_ex;
    string       got_name;
    logic [31:0] got_result;
    logic        got_ex;
    logic [4:0]  got_dest;
    logic        got_we;
    logic        got_timed;
    int          got_cycle;

    // expected results, in acceptance order
    logic [31:0] exp_result_q [$];
    logic        exp_ex_q [$];
    logic [4:0]  exp_dest_q [$];
    logic        exp_we_q [$];
    logic        timed_q [$];
    int          accept_q [$];
    string       name_q [$];

    always #4 clk = ~clk;

    mem_pipe i_mem_pipe (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_allowin  (in_allowin),
        .in_op       (in_op),
        .in_addr     (in_addr),
        .in_rt       (in_rt),
        .in_dest     (in_dest),
        .in_we       (in_we),
        .out_valid   (out_valid),
        .out_allowin (out_allowin),
        .out_we      (out_we),
        .out_dest    (out_dest),
        .out_result  (out_result),
        .out_ex      (out_ex),
        .fwd_dest    (fwd_dest),
        .fwd_result  (fwd_result),
        .mem_stall   (mem_stall)
    );

    bind mem_pipe mem_pipe_asserts i_asserts (
        .clk         (clk),
        .reset       (reset),
        .in_allowin  (in_allowin),
        .out_valid   (out_valid),
        .out_allowin (out_allowin),
        .out_dest    (out_dest),
        .fwd_dest    (fwd_dest),
        .ram_we      (ram_we)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] word_addr(input int w, input int off);
        return {26'd0, 4'(w), 2'(off)};
    endfunction

    // shadow memory model, little endian MIPS rules
    function automatic logic [31:0] expect_result(input logic [op_w-1:0] op,
            input logic [31:0] addr, input logic [31:0] rt, output logic ex);
        logic [3:0]  idx;
        logic [31:0] word;
        logic [31:0] res;
        logic [7:0]  b;
        logic [15:0] h;
        int          off;
        idx  = addr[5:2];
        off  = {30'd0, addr[1:0]};
        word = shadow[idx];
        b    = word[8*off +: 8];
        h    = word[16*(off/2) +: 16];
        res  = addr;  // stores and pass ops hand back the alu value
        ex   = ((op == OP_LH || op == OP_LHU || op == OP_SH) && addr[0]) ||
               ((op == OP_LW || op == OP_SW) && addr[1:0] != 2'b00);
        case (op)
            OP_LB:  res = {{24{b[7]}}, b};
            OP_LBU: res = {24'd0, b};
            OP_LH:  res = {{16{h[15]}}, h};
            OP_LHU: res = {16'd0, h};
            OP_LW:  res = word;
            OP_LWL: begin
                res = rt;
                for (int i = 0; i <= off; i++) begin
                    res[8*(3-off+i) +: 8] = word[8*i +: 8];  // memory bytes fill the top
                end
            end
            OP_LWR: begin
                res = rt;
                for (int i = off; i < 4; i++) begin
                    res[8*(i-off) +: 8] = word[8*i +: 8];
                end
            end
            OP_SB: shadow[idx][8*off +: 8] = rt[7:0];
            OP_SH: begin
                if (!ex) begin
                    shadow[idx][16*(off/2) +: 16] = rt[15:0];
                end
            end
            OP_SW: begin
                if (!ex) begin
                    shadow[idx] = rt;
                end
            end
            OP_SWL: begin
                for (int i = 0; i <= off; i++) begin
                    shadow[idx][8*i +: 8] = rt[8*(3-off+i) +: 8];
                end
            end
            OP_SWR: begin
                for (int i = off; i < 4; i++) begin
                    shadow[idx][8*i +: 8] = rt[8*(i-off) +: 8];
                end
            end
            default: ;
        endcase
        return res;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_dest(input string name, input logic [4:0] expected,
            input logic [4:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic update_ready();
        if (random_ready) begin
            out_allowin = (take_bits(2) != 0);  // mostly ready
            mem_stall   = (take_bits(2) == 3);
        end
    endtask

    // called at a falling edge, returns at the falling edge after the handshake
    task automatic drive_op(input logic [op_w-1:0] op, input logic [31:0] addr,
            input logic [31:0] rt);
        in_valid = 1'b1;
        in_op    = op;
        in_addr  = addr;
        in_rt    = rt;
        in_dest  = 5'(take_bits(5));
        in_we    = 1'(take_bits(1));
        do begin
            @(negedge clk);
            update_ready();
        end while (!in_fire);
        in_valid = 1'b0;
    endtask

    task automatic store_and_reload(input logic [op_w-1:0] op, input int off);
        int w;
        w = take_bits(4);
        drive_op(op, word_addr(w, off), take_bits(32));
        drive_op(OP_LW, word_addr(w, 0), take_bits(32));
    endtask

    task automatic wait_drain();
        while (exp_result_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // input handshake feeds the reference model
    always @(posedge clk) begin
        in_fire = !reset && in_valid && in_allowin;
        if (in_fire) begin
            ref_result = expect_result(in_op, in_addr, in_rt, ref_ex);
            exp_result_q.push_back(ref_result);
            exp_ex_q.push_back(ref_ex);
            exp_dest_q.push_back(in_dest);
            exp_we_q.push_back(in_we);
            timed_q.push_back(timed);
            accept_q.push_back(cycle);
            name_q.push_back($sformatf("%s op %0d", test_name, accepted));
            accepted++;
        end
    end

    always @(posedge clk) begin
        if (!reset && out_valid && out_allowin) begin
            if (exp_result_q.size() == 0) begin
                abort_run("a result left the pipe with no operation outstanding");
            end else begin
                got_name   = name_q.pop_front();
                got_result = exp_result_q.pop_front();
                got_ex     = exp_ex_q.pop_front();
                got_dest   = exp_dest_q.pop_front();
                got_we     = exp_we_q.pop_front();
                got_timed  = timed_q.pop_front();
                got_cycle  = accept_q.pop_front();
                check_flag({got_name, " ex"}, got_ex, out_ex);
                check_flag({got_name, " we"}, got_we, out_we);
                check_dest({got_name, " dest"}, got_dest, out_dest);
                check_dest({got_name, " fwd dest"}, got_dest, fwd_dest);
                if (!got_ex) begin  // a faulting load has no defined data
                    check_word({got_name, " result"}, got_result, out_result);
                    check_word({got_name, " fwd result"}, got_result, fwd_result);
                end
                if (got_timed && cycle - got_cycle != 2) begin
                    abort_run($sformatf("%s came out %0d cycles after it went in, not 2",
                        got_name, cycle - got_cycle));
                end
                retired++;
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles with %0d results still missing",
                cycle, exp_result_q.size()));
        end
    end

    initial begin
        int w;
        logic [op_w-1:0] op;
        logic [31:0]     addr;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_op        = OP_PASS;
        in_addr      = 32'd0;
        in_rt        = 32'd0;
        in_dest      = 5'd0;
        in_we        = 1'b0;
        out_allowin  = 1'b1;
        mem_stall    = 1'b0;
        lfsr_state   = seed;
        random_ready = 1'b0;
        timed        = 1'b1;
        in_fire      = 1'b0;
        test_name    = "reset";
        repeat (4) @(negedge clk);
        reset = 1'b0;

        test_name = "sw/lw fill";
        for (int i = 0; i < 16; i++) begin
            drive_op(OP_SW, word_addr(i, 0), take_bits(32));
        end
        for (int i = 0; i < 16; i++) begin
            drive_op(OP_LW, word_addr(i, 0), take_bits(32));
        end

        test_name = "sub-word loads";
        for (int k = 0; k < 4; k++) begin
            w = take_bits(4);
            for (int off = 0; off < 4; off++) begin
                drive_op(OP_LB, word_addr(w, off), take_bits(32));
                drive_op(OP_LBU, word_addr(w, off), take_bits(32));
            end
            for (int off = 0; off < 4; off += 2) begin
                drive_op(OP_LH, word_addr(w, off), take_bits(32));
                drive_op(OP_LHU, word_addr(w, off), take_bits(32));
            end
        end

        test_name = "partial stores";
        for (int off = 0; off < 4; off++) begin
            store_and_reload(OP_SB, off);
            store_and_reload(OP_SWL, off);
            store_and_reload(OP_SWR, off);
        end
        store_and_reload(OP_SH, 0);
        store_and_reload(OP_SH, 2);

        test_name = "lwl/lwr merge";
        for (int off = 0; off < 4; off++) begin
            w = take_bits(4);
            drive_op(OP_LWL, word_addr(w, off), take_bits(32));
            drive_op(OP_LWR, word_addr(w, off), take_bits(32));
        end

        test_name = "misaligned";
        for (int off = 1; off < 4; off += 2) begin
            drive_op(OP_LH, word_addr(take_bits(4), off), take_bits(32));
            drive_op(OP_LHU, word_addr(take_bits(4), off), take_bits(32));
            store_and_reload(OP_SH, off);
        end
        for (int off = 1; off < 4; off++) begin
            drive_op(OP_LW, word_addr(take_bits(4), off), take_bits(32));
            store_and_reload(OP_SW, off);
        end

        test_name = "pass-through";
        repeat (8) drive_op(OP_PASS, take_bits(32), take_bits(32));

        // latency is only fixed while both ends stay ready
        wait_drain();
        test_name    = "random traffic";
        timed        = 1'b0;
        random_ready = 1'b1;
        repeat (n_random) begin
            if (take_bits(2) == 0) begin
                @(negedge clk);  // bubble on the input side
                update_ready();
            end
            op   = 4'(take_bits(4) % 13);
            addr = (op == OP_PASS) ? take_bits(32) : {26'd0, 6'(take_bits(6))};
            drive_op(op, addr, take_bits(32));
        end
        random_ready = 1'b0;
        out_allowin  = 1'b1;
        mem_stall    = 1'b0;
        wait_drain();

        if (retired == accepted && accepted == total_ops) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            abort_run($sformatf("%0d operations went in but %0d results came out",
                accepted, retired));
        end
    end

endmodule
